/* io_bridge_pkg.sv */
`default_nettype none

package io_bridge_pkg;

  // Command address and data word
  localparam int IO_ADDR_WIDTH = 28;
  localparam int IO_DATA_WIDTH = 32;

  // Device select field inside the address
  localparam int IO_DEV_LSB   = 20;
  localparam int IO_DEV_WIDTH = 4;

  // Only this device code goes to the manycore target
  localparam logic [IO_DEV_WIDTH-1:0] IO_DEV_MC = 4'h2;

  // Default entries per queue
  localparam int IO_FIFO_DEPTH = 4;

  typedef enum logic [1:0]
  {
    e_io_op_read  = 2'b00
    , e_io_op_write = 2'b01
    , e_io_op_error = 2'b10
  } io_op_e;

  typedef struct packed
  {
    io_op_e                   op;
    logic [IO_ADDR_WIDTH-1:0] addr;
    logic [IO_DATA_WIDTH-1:0] data;
  } io_cmd_t;

  // Command layout under a distinct type
  typedef struct packed
  {
    io_op_e                   op;
    logic [IO_ADDR_WIDTH-1:0] addr;
    logic [IO_DATA_WIDTH-1:0] data;
  } io_resp_t;

endpackage

`default_nettype wire

/* io_fifo.sv */
`timescale 1ns/1ps
`default_nettype none

module io_fifo
  import io_bridge_pkg::*;
  #(parameter type payload_t = io_cmd_t
    , parameter int depth_p  = IO_FIFO_DEPTH
    )
  (input  logic       clk_i
   , input  logic     rst_i

   , input  payload_t enq_i
   , input  logic     enq_v_i
   , output logic     enq_ready_o

   , output payload_t deq_o
   , output logic     deq_v_o
   , input  logic     deq_yumi_i
   );

  typedef logic [$clog2(depth_p)-1:0]   ptr_t;
  typedef logic [$clog2(depth_p+1)-1:0] cnt_t;

  payload_t mem_r [depth_p];
  ptr_t     rd_ptr_r;
  ptr_t     wr_ptr_r;
  cnt_t     count_r;
  logic     enq_fire;
  logic     deq_fire;

  assign enq_ready_o = (count_r != cnt_t'(depth_p));
  assign deq_v_o     = (count_r != '0);
  assign enq_fire    = enq_v_i & enq_ready_o;
  assign deq_fire    = deq_yumi_i & deq_v_o;

  // Head comes straight out of the array
  assign deq_o = mem_r[rd_ptr_r];

  always_ff @(posedge clk_i)
  begin
    if (enq_fire)
      mem_r[wr_ptr_r] <= enq_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      rd_ptr_r <= '0;
      wr_ptr_r <= '0;
      count_r  <= '0;
    end
    else
    begin
      if (enq_fire)
        wr_ptr_r <= (wr_ptr_r == ptr_t'(depth_p - 1)) ? '0 : wr_ptr_r + 1'b1;
      if (deq_fire)
        rd_ptr_r <= (rd_ptr_r == ptr_t'(depth_p - 1)) ? '0 : rd_ptr_r + 1'b1;
      case ({enq_fire, deq_fire})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // Entry refused by a full queue stays offered unchanged
  a_no_enq_when_full: assert property (@(posedge clk_i) disable iff (rst_i)
    (enq_v_i && !enq_ready_o) |=> (enq_v_i && $stable(enq_i)));

  a_no_yumi_when_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    deq_yumi_i |-> deq_v_o);

endmodule

`default_nettype wire

/* io_cmd_steer.sv */
`timescale 1ns/1ps
`default_nettype none

module io_cmd_steer
  import io_bridge_pkg::*;
  (input  logic      clk_i
   , input  logic    rst_i

   // Incoming valid/ready command
   , input  io_cmd_t cmd_i
   , input  logic    cmd_v_i
   , output logic    cmd_ready_o

   // Shared payload toward both target queues
   , output io_cmd_t steer_cmd_o
   , output logic    mc_v_o
   , input  logic    mc_ready_i
   , output logic    mmio_v_o
   , input  logic    mmio_ready_i
   );

  io_cmd_t cmd_r;
  logic    cmd_v_r;
  logic    is_mc_r;
  logic    dev_is_mc;
  logic    accept;
  logic    drain;

  // Device field picks the target
  assign dev_is_mc = (cmd_i.addr[IO_DEV_LSB +: IO_DEV_WIDTH] == IO_DEV_MC);

  // Only the addressed queue can stall us
  assign drain       = cmd_v_r & (is_mc_r ? mc_ready_i : mmio_ready_i);
  assign cmd_ready_o = ~cmd_v_r | drain;
  assign accept      = cmd_v_i & cmd_ready_o;

  assign steer_cmd_o = cmd_r;
  assign mc_v_o      = cmd_v_r & is_mc_r;
  assign mmio_v_o    = cmd_v_r & ~is_mc_r;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      cmd_v_r <= 1'b0;
      is_mc_r <= 1'b0;
    end
    else if (accept)
    begin
      cmd_v_r <= 1'b1;
      is_mc_r <= dev_is_mc;
    end
    else if (drain)
    begin
      cmd_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (accept)
      cmd_r <= cmd_i;
  end

  a_one_target: assert property (@(posedge clk_i) disable iff (rst_i)
    $onehot0({mc_v_o, mmio_v_o}));

endmodule

`default_nettype wire

/* io_resp_merge.sv */
`timescale 1ns/1ps
`default_nettype none

module io_resp_merge
  import io_bridge_pkg::*;
  (input  logic       clk_i
   , input  logic     rst_i

   , input  io_resp_t mc_resp_i
   , input  logic     mc_resp_v_i
   , output logic     mc_resp_yumi_o

   , input  io_resp_t mmio_resp_i
   , input  logic     mmio_resp_v_i
   , output logic     mmio_resp_yumi_o

   , output io_resp_t merged_o
   , output logic     merged_v_o
   , input  logic     merged_ready_i
   );

  io_resp_t merged_r;
  logic     merged_v_r;
  logic     load_en;
  logic     take_mmio;
  logic     take_mc;

  // Register is free when empty or handing off this edge
  assign load_en = ~merged_v_r | merged_ready_i;

  // MMIO wins a tie
  assign take_mmio = load_en & mmio_resp_v_i;
  assign take_mc   = load_en & ~mmio_resp_v_i & mc_resp_v_i;

  assign mmio_resp_yumi_o = take_mmio;
  assign mc_resp_yumi_o   = take_mc;

  assign merged_o   = merged_r;
  assign merged_v_o = merged_v_r;

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
      merged_v_r <= 1'b0;
    else if (load_en)
      merged_v_r <= take_mmio | take_mc;
  end

  always_ff @(posedge clk_i)
  begin
    if (take_mmio)
      merged_r <= mmio_resp_i;
    else if (take_mc)
      merged_r <= mc_resp_i;
  end

  a_one_yumi: assert property (@(posedge clk_i) disable iff (rst_i)
    !(mc_resp_yumi_o && mmio_resp_yumi_o));

  // Losing manycore response stays offered until served
  a_mc_resp_held: assert property (@(posedge clk_i) disable iff (rst_i)
    (mc_resp_v_i && !mc_resp_yumi_o) |=> (mc_resp_v_i && $stable(mc_resp_i)));

endmodule

`default_nettype wire

/* io_bridge_tile.sv */
`timescale 1ns/1ps
`default_nettype none

module io_bridge_tile
  import io_bridge_pkg::*;
  (input  logic       clk_i
   , input  logic     rst_i

   , input  io_cmd_t  cmd_i
   , input  logic     cmd_v_i
   , output logic     cmd_ready_o

   , output io_cmd_t  mc_cmd_o
   , output logic     mc_cmd_v_o
   , input  logic     mc_cmd_yumi_i

   , output io_cmd_t  mmio_cmd_o
   , output logic     mmio_cmd_v_o
   , input  logic     mmio_cmd_yumi_i

   , input  io_resp_t mc_resp_i
   , input  logic     mc_resp_v_i
   , output logic     mc_resp_yumi_o

   , input  io_resp_t mmio_resp_i
   , input  logic     mmio_resp_v_i
   , output logic     mmio_resp_yumi_o

   , output io_resp_t resp_o
   , output logic     resp_v_o
   , input  logic     resp_yumi_i
   );

  io_cmd_t  steer_cmd_lo;
  logic     steer_mc_v_lo, mc_fifo_ready_li;
  logic     steer_mmio_v_lo, mmio_fifo_ready_li;
  io_resp_t merged_lo;
  logic     merged_v_lo, resp_fifo_ready_li;

  io_cmd_steer steer
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.cmd_i(cmd_i)
     ,.cmd_v_i(cmd_v_i)
     ,.cmd_ready_o(cmd_ready_o)
     ,.steer_cmd_o(steer_cmd_lo)
     ,.mc_v_o(steer_mc_v_lo)
     ,.mc_ready_i(mc_fifo_ready_li)
     ,.mmio_v_o(steer_mmio_v_lo)
     ,.mmio_ready_i(mmio_fifo_ready_li)
     );

  io_fifo #(.payload_t(io_cmd_t), .depth_p(IO_FIFO_DEPTH)) mc_cmd_fifo
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.enq_i(steer_cmd_lo)
     ,.enq_v_i(steer_mc_v_lo)
     ,.enq_ready_o(mc_fifo_ready_li)
     ,.deq_o(mc_cmd_o)
     ,.deq_v_o(mc_cmd_v_o)
     ,.deq_yumi_i(mc_cmd_yumi_i)
     );

  io_fifo #(.payload_t(io_cmd_t), .depth_p(IO_FIFO_DEPTH)) mmio_cmd_fifo
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.enq_i(steer_cmd_lo)
     ,.enq_v_i(steer_mmio_v_lo)
     ,.enq_ready_o(mmio_fifo_ready_li)
     ,.deq_o(mmio_cmd_o)
     ,.deq_v_o(mmio_cmd_v_o)
     ,.deq_yumi_i(mmio_cmd_yumi_i)
     );

  io_resp_merge merge
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.mc_resp_i(mc_resp_i)
     ,.mc_resp_v_i(mc_resp_v_i)
     ,.mc_resp_yumi_o(mc_resp_yumi_o)
     ,.mmio_resp_i(mmio_resp_i)
     ,.mmio_resp_v_i(mmio_resp_v_i)
     ,.mmio_resp_yumi_o(mmio_resp_yumi_o)
     ,.merged_o(merged_lo)
     ,.merged_v_o(merged_v_lo)
     ,.merged_ready_i(resp_fifo_ready_li)
     );

  io_fifo #(.payload_t(io_resp_t), .depth_p(IO_FIFO_DEPTH)) resp_fifo
    (.clk_i(clk_i)
     ,.rst_i(rst_i)
     ,.enq_i(merged_lo)
     ,.enq_v_i(merged_v_lo)
     ,.enq_ready_o(resp_fifo_ready_li)
     ,.deq_o(resp_o)
     ,.deq_v_o(resp_v_o)
     ,.deq_yumi_i(resp_yumi_i)
     );

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen
  #(parameter int period_p = 8
    , parameter int reset_cycles_p = 8
    )
  (output logic clk_o
   , output logic rst_o
   );

  initial
  begin
    clk_o = 1'b0;
    forever
      #(period_p / 2) clk_o = ~clk_o;
  end

  // Reset drops just after an edge, like all other stimulus
  initial
  begin
    rst_o = 1'b1;
    repeat (reset_cycles_p) @(posedge clk_o);
    #1;
    rst_o = 1'b0;
  end

endmodule

`default_nettype wire

/* tb_io_bridge_tile.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_io_bridge_tile
  import io_bridge_pkg::*;
  ();

  localparam int          MAX_CYCLES  = 2000;
  localparam int          RANDOM_CMDS = 200;
  localparam logic [31:0] SEED        = 32'hc3dfa57c;

  logic     clk, rst;
  io_cmd_t  cmd, mc_cmd, mmio_cmd;
  logic     cmd_v, cmd_ready;
  logic     mc_cmd_v, mc_cmd_yumi, mmio_cmd_v, mmio_cmd_yumi;
  io_resp_t mc_resp, mmio_resp, resp;
  logic     mc_resp_v, mc_resp_yumi, mmio_resp_v, mmio_resp_yumi;
  logic     resp_v, resp_yumi;

  // Commands still to send, then per-target and response scoreboards
  io_cmd_t  cmd_src_q[$];
  io_cmd_t  exp_mc_q[$];
  io_cmd_t  exp_mmio_q[$];
  io_resp_t mc_pend_q[$];
  io_resp_t mmio_pend_q[$];
  io_resp_t exp_resp_q[$];
  io_resp_t got_q[$];

  logic mc_hold, resp_hold;
  int   cmd_gap_pct, out_gap_pct;
  int   error_count, cycle_count;

  tb_clk_gen #(.period_p(8), .reset_cycles_p(8)) clk_gen
    (.clk_o(clk)
     ,.rst_o(rst)
     );

  io_bridge_tile dut_i
    (.clk_i(clk), .rst_i(rst)
     ,.cmd_i(cmd), .cmd_v_i(cmd_v), .cmd_ready_o(cmd_ready)
     ,.mc_cmd_o(mc_cmd), .mc_cmd_v_o(mc_cmd_v), .mc_cmd_yumi_i(mc_cmd_yumi)
     ,.mmio_cmd_o(mmio_cmd), .mmio_cmd_v_o(mmio_cmd_v), .mmio_cmd_yumi_i(mmio_cmd_yumi)
     ,.mc_resp_i(mc_resp), .mc_resp_v_i(mc_resp_v), .mc_resp_yumi_o(mc_resp_yumi)
     ,.mmio_resp_i(mmio_resp), .mmio_resp_v_i(mmio_resp_v), .mmio_resp_yumi_o(mmio_resp_yumi)
     ,.resp_o(resp), .resp_v_o(resp_v), .resp_yumi_i(resp_yumi)
     );

  function automatic logic routes_to_mc(input io_cmd_t c);
    return (c.addr[IO_DEV_LSB +: IO_DEV_WIDTH] == IO_DEV_MC);
  endfunction

  // Targets answer with the command fields unchanged
  function automatic io_resp_t echo_of(input io_cmd_t c);
    io_resp_t r;
    r.op   = c.op;
    r.addr = c.addr;
    r.data = c.data;
    return r;
  endfunction

  function automatic io_cmd_t make_cmd(input logic [IO_DEV_WIDTH-1:0] dev);
    io_cmd_t c;
    c.op   = io_op_e'(2'($urandom_range(2)));
    c.addr = IO_ADDR_WIDTH'($urandom);
    c.addr[IO_DEV_LSB +: IO_DEV_WIDTH] = dev;
    c.data = $urandom;
    return c;
  endfunction

  task automatic stop_run();
    $display("*** FAILED ***");
    $fatal(1, "run stopped at first error");
  endtask

  task automatic report_failure(input string why);
    error_count++;
    $display("Error at %0d ns: %s", $time, why);
    stop_run();
  endtask

  task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp)
    begin
      error_count++;
      $display("** Error at %0d ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
      stop_run();
    end
  endtask

  task automatic drive_inputs();
    if (rst)
    begin
      cmd_v         = 1'b0;
      cmd           = '0;
      mc_cmd_yumi   = 1'b0;
      mmio_cmd_yumi = 1'b0;
      mc_resp_v     = 1'b0;
      mc_resp       = '0;
      mmio_resp_v   = 1'b0;
      mmio_resp     = '0;
      resp_yumi     = 1'b0;
    end
    else
    begin
      cmd_v         = (cmd_src_q.size() != 0);
      cmd           = cmd_v ? cmd_src_q[0] : '0;
      mc_cmd_yumi   = mc_cmd_v && !mc_hold && (int'($urandom_range(99)) >= cmd_gap_pct);
      mmio_cmd_yumi = mmio_cmd_v && (int'($urandom_range(99)) >= cmd_gap_pct);
      // A presented response stays until its yumi
      mc_resp_v     = !resp_hold && (mc_pend_q.size() != 0);
      mc_resp       = mc_resp_v ? mc_pend_q[0] : '0;
      mmio_resp_v   = !resp_hold && (mmio_pend_q.size() != 0);
      mmio_resp     = mmio_resp_v ? mmio_pend_q[0] : '0;
      resp_yumi     = resp_v && (int'($urandom_range(99)) >= out_gap_pct);
    end
  endtask

  task automatic observe_cycle();
    io_cmd_t c;
    int      idx;
    if (!rst)
    begin
      if (cmd_v && cmd_ready)
      begin
        c = cmd_src_q.pop_front();
        if (routes_to_mc(c))
          exp_mc_q.push_back(c);
        else
          exp_mmio_q.push_back(c);
      end
      if (mc_cmd_yumi)
      begin
        if (exp_mc_q.size() == 0)
          report_failure("manycore target received a command routed elsewhere");
        else
        begin
          c = exp_mc_q.pop_front();
          check_eq("mc_cmd_o", 64'(mc_cmd), 64'(c));
          mc_pend_q.push_back(echo_of(c));
          exp_resp_q.push_back(echo_of(c));
        end
      end
      if (mmio_cmd_yumi)
      begin
        if (exp_mmio_q.size() == 0)
          report_failure("MMIO target received a command routed elsewhere");
        else
        begin
          c = exp_mmio_q.pop_front();
          check_eq("mmio_cmd_o", 64'(mmio_cmd), 64'(c));
          mmio_pend_q.push_back(echo_of(c));
          exp_resp_q.push_back(echo_of(c));
        end
      end
      if (mc_resp_v && mc_resp_yumi)
        void'(mc_pend_q.pop_front());
      if (mmio_resp_v && mmio_resp_yumi)
        void'(mmio_pend_q.pop_front());
      if (resp_v && resp_yumi)
      begin
        idx = -1;
        foreach (exp_resp_q[i])
          if (idx < 0 && exp_resp_q[i] == resp)
            idx = i;
        if (idx < 0)
          report_failure($sformatf("resp_o 0x%0h matches no outstanding response", resp));
        else
        begin
          exp_resp_q.delete(idx);
          got_q.push_back(resp);
        end
      end
    end
  endtask

  task automatic wait_idle();
    while (cmd_src_q.size() != 0 || exp_mc_q.size() != 0 || exp_mmio_q.size() != 0
           || mc_pend_q.size() != 0 || mmio_pend_q.size() != 0 || exp_resp_q.size() != 0)
      @(negedge clk);
    // Nothing extra may be left in any queue
    repeat (4) @(negedge clk);
    check_eq("mc_cmd_v_o", 64'(mc_cmd_v), 64'd0);
    check_eq("mmio_cmd_v_o", 64'(mmio_cmd_v), 64'd0);
    check_eq("resp_v_o", 64'(resp_v), 64'd0);
  endtask

  task automatic check_reset_outputs();
    check_eq("cmd_ready_o", 64'(cmd_ready), 64'd1);
    check_eq("mc_cmd_v_o", 64'(mc_cmd_v), 64'd0);
    check_eq("mmio_cmd_v_o", 64'(mmio_cmd_v), 64'd0);
    check_eq("resp_v_o", 64'(resp_v), 64'd0);
    check_eq("mc_resp_yumi_o", 64'(mc_resp_yumi), 64'd0);
    check_eq("mmio_resp_yumi_o", 64'(mmio_resp_yumi), 64'd0);
  endtask

  task automatic reset_state_test();
    repeat (3) @(negedge clk);
    check_reset_outputs();
    while (rst)
      @(negedge clk);
    check_reset_outputs();
  endtask

  task automatic routing_test();
    for (int d = 0; d < (1 << IO_DEV_WIDTH); d++)
      cmd_src_q.push_back(make_cmd(IO_DEV_WIDTH'(d)));
    wait_idle();
  endtask

  task automatic backpressure_test();
    mc_hold = 1'b1;
    for (int n = 0; n < IO_FIFO_DEPTH + 2; n++)
      cmd_src_q.push_back(make_cmd(IO_DEV_MC));
    // Queue plus steer register hold all but the last one
    while (cmd_src_q.size() > 1)
      @(negedge clk);
    repeat (4) @(negedge clk);
    check_eq("cmd_ready_o", 64'(cmd_ready), 64'd0);
    check_eq("mc_cmd_v_o", 64'(mc_cmd_v), 64'd1);
    check_eq("commands waiting at cmd_i", 64'(cmd_src_q.size()), 64'd1);
    mc_hold = 1'b0;
    wait_idle();
  endtask

  task automatic priority_test();
    io_resp_t mc_exp;
    io_resp_t mmio_exp;
    resp_hold = 1'b1;
    got_q.delete();
    cmd_src_q.push_back(make_cmd(IO_DEV_MC));
    cmd_src_q.push_back(make_cmd(~IO_DEV_MC));
    while (mc_pend_q.size() == 0 || mmio_pend_q.size() == 0)
      @(negedge clk);
    mc_exp    = mc_pend_q[0];
    mmio_exp  = mmio_pend_q[0];
    resp_hold = 1'b0;
    while (got_q.size() < 2)
      @(negedge clk);
    check_eq("first resp_o", 64'(got_q[0]), 64'(mmio_exp));
    check_eq("second resp_o", 64'(got_q[1]), 64'(mc_exp));
    wait_idle();
  endtask

  task automatic random_mix_test();
    logic [IO_DEV_WIDTH-1:0] dev;
    cmd_gap_pct = 30;
    out_gap_pct = 30;
    for (int n = 0; n < RANDOM_CMDS; n++)
    begin
      dev = ($urandom_range(2) == 0) ? IO_DEV_MC : IO_DEV_WIDTH'($urandom_range(15));
      cmd_src_q.push_back(make_cmd(dev));
    end
    wait_idle();
    cmd_gap_pct = 0;
    out_gap_pct = 0;
  endtask

  // Target and consumer models drive after the edge and sample mid-cycle
  initial
  begin
    forever
    begin
      @(posedge clk);
      #1;
      drive_inputs();
      @(negedge clk);
      observe_cycle();
    end
  end

  initial
  begin
    cycle_count = 0;
    while (cycle_count < MAX_CYCLES)
    begin
      @(posedge clk);
      cycle_count++;
    end
    report_failure($sformatf("timeout after %0d cycles, the DUT stopped moving", MAX_CYCLES));
  end

  initial
  begin
    cmd            = '0;
    cmd_v          = 1'b0;
    mc_cmd_yumi    = 1'b0;
    mmio_cmd_yumi  = 1'b0;
    mc_resp        = '0;
    mc_resp_v      = 1'b0;
    mmio_resp      = '0;
    mmio_resp_v    = 1'b0;
    resp_yumi      = 1'b0;
    mc_hold        = 1'b0;
    resp_hold      = 1'b0;
    cmd_gap_pct    = 0;
    out_gap_pct    = 0;
    error_count    = 0;
    void'($urandom(SEED));

    reset_state_test();
    routing_test();
    backpressure_test();
    priority_test();
    random_mix_test();

    if (error_count == 0)
    begin
      $display("*** PASSED ***");
      $finish;
    end
    else
      stop_run();
  end

endmodule

`default_nettype wire

/* io_bridge_tile.f */
io_bridge_pkg.sv
io_fifo.sv
io_cmd_steer.sv
io_resp_merge.sv
io_bridge_tile.sv
tb_clk_gen.sv
tb_io_bridge_tile.sv

/* run_sim.sh */
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the log

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 \
    --timescale 1ns/1ps \
    --top-module tb_io_bridge_tile \
    -f io_bridge_tile.f \
    -o sim_io_bridge_tile; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_io_bridge_tile > sim.log 2>&1
status=$?
cat sim.log

if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q '^\*\*\* PASSED \*\*\*$' sim.log; then
  exit 0
else
  echo "Pass message not found in sim.log"
  exit 1
fi
